/* files.f */
+incdir+.
motor_pkg.sv
param_bank.sv
tick_gen.sv
wave_ctrl.sv
wave_buffer.sv
spike_window.sv
reflex_core.sv
tb_reflex_core.sv

/* motor_cfg.svh */
`ifndef MOTOR_CFG_SVH
`define MOTOR_CFG_SVH

//////////////////////////////
// word widths
//////////////////////////////
// sample or parameter word
`define MOTOR_WORD_W 32
// host wire word, also the tick half-count
`define MOTOR_HALF_W 16
`define MOTOR_SPIKE_CNT_W 16

// stored samples in the waveform memory
`define MOTOR_WAVE_DEPTH 16

//////////////////////////////
// host trigger slots
//////////////////////////////
// bit positions kept from the board trigger word
`define MOTOR_SLOT_HALF_CNT 0
`define MOTOR_SLOT_GAIN 3
`define MOTOR_SLOT_LEN_OVR 7
`define MOTOR_SLOT_LEN_PXI 8

// reset defaults
// default length is 0.9 in single precision
`define MOTOR_DEF_HALF_CNT 16'd4
`define MOTOR_DEF_GAIN 32'd0
`define MOTOR_DEF_LEN_PXI 32'h3F66_6666

`endif

/* motor_pkg.sv */
`default_nettype none

package motor_pkg;

`include "motor_cfg.svh"

    //////////////////////////////
    // payload types
    //////////////////////////////

    // one sample or parameter, full word
    typedef logic [`MOTOR_WORD_W-1:0] word_t;

    // one host wire or pipe word
    typedef logic [`MOTOR_HALF_W-1:0] half_t;

    // spikes per simulation step
    typedef logic [`MOTOR_SPIKE_CNT_W-1:0] spike_cnt_t;

    // index into the waveform memory
    typedef logic [$clog2(`MOTOR_WAVE_DEPTH)-1:0] wave_addr_t;

    //////////////////////////////
    // playback states
    //////////////////////////////

    // empty until the first sample lands, fill until the first tick
    typedef enum logic [1:0]
    {
        EMPTY,
        FILL,
        PLAY
    } wave_state_e;

endpackage

`default_nettype wire

/* param_bank.sv */
`timescale 1ns/10ps
`default_nettype none
`include "motor_cfg.svh"

module param_bank
    import motor_pkg::*;
(
    input  wire        i_ep50trig,
    input  wire        i_reset_global,
    input  wire [15:0] i_trig,
    input  wire half_t i_wire_lo,
    input  wire half_t i_wire_hi,
    output half_t      o_half_cnt,
    output word_t      o_gain,
    output logic       o_len_ovr,
    output word_t      o_len_pxi
);

    half_t half_cnt_q;
    word_t gain_q;
    logic  len_ovr_q;
    word_t len_pxi_q;

    //////////////////////////////
    // one register per trigger slot
    //////////////////////////////

    // tick half-count, low wire only
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            half_cnt_q <= `MOTOR_DEF_HALF_CNT;
        else if (i_trig[`MOTOR_SLOT_HALF_CNT])
            half_cnt_q <= i_wire_lo;
    end

    // spike count gain
    // hi wire is the upper half
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            gain_q <= `MOTOR_DEF_GAIN;
        else if (i_trig[`MOTOR_SLOT_GAIN])
            gain_q <= {i_wire_hi, i_wire_lo};
    end

    // length override enable
    // only bit 0 of the low wire matters
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            len_ovr_q <= 1'b0;
        else if (i_trig[`MOTOR_SLOT_LEN_OVR])
            len_ovr_q <= i_wire_lo[0];
    end

    // override length from the host
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
            len_pxi_q <= `MOTOR_DEF_LEN_PXI;
        else if (i_trig[`MOTOR_SLOT_LEN_PXI])
            len_pxi_q <= {i_wire_hi, i_wire_lo};
    end

    assign o_half_cnt = half_cnt_q;
    assign o_gain     = gain_q;
    assign o_len_ovr  = len_ovr_q;
    assign o_len_pxi  = len_pxi_q;

    // flag steers the top level length mux every cycle
    a_len_ovr_known: assert property (
        @(posedge i_ep50trig) disable iff (i_reset_global)
        !$isunknown(len_ovr_q)
    );

endmodule

`default_nettype wire

/* reflex_core.sv */
`timescale 1ns/10ps
`default_nettype none

module reflex_core
    import motor_pkg::*;
(
    input  wire        i_ep50trig,
    input  wire        i_reset_global,
    input  wire [15:0] i_trig,
    input  wire half_t i_wire_lo,
    input  wire half_t i_wire_hi,
    input  wire        i_pipe_write,
    input  wire half_t i_pipe_data,
    input  wire        i_wave_restart,
    input  wire        i_spike,
    output logic       o_sim_tick,
    output word_t      o_len,
    output spike_cnt_t o_spike_cnt,
    output word_t      o_drive
);

    half_t      half_cnt;
    word_t      gain;
    logic       len_ovr;
    word_t      len_pxi;
    word_t      wave;
    logic       wr_en;
    logic       pair_hi;
    logic       rd_en;
    wave_addr_t wr_addr;
    wave_addr_t rd_addr;

    //////////////////////////////
    // host parameters and timing
    //////////////////////////////

    param_bank u_param_bank (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_trig         (i_trig),
        .i_wire_lo      (i_wire_lo),
        .i_wire_hi      (i_wire_hi),
        .o_half_cnt     (half_cnt),
        .o_gain         (gain),
        .o_len_ovr      (len_ovr),
        .o_len_pxi      (len_pxi)
    );

    tick_gen u_tick_gen (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_half_cnt     (half_cnt),
        .o_sim_tick     (o_sim_tick)
    );

    //////////////////////////////
    // waveform store
    //////////////////////////////

    wave_ctrl u_wave_ctrl (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_wave_restart (i_wave_restart),
        .i_pipe_write   (i_pipe_write),
        .i_sim_tick     (o_sim_tick),
        .o_wr_en        (wr_en),
        .o_wr_addr      (wr_addr),
        .o_rd_en        (rd_en),
        .o_rd_addr      (rd_addr),
        .o_pair_hi      (pair_hi)
    );

    wave_buffer u_wave_buffer (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_wave_restart (i_wave_restart),
        .i_pipe_data    (i_pipe_data),
        .i_wr_en        (wr_en),
        .i_pair_hi      (pair_hi),
        .i_wr_addr      (wr_addr),
        .i_rd_en        (rd_en),
        .i_rd_addr      (rd_addr),
        .o_wave         (wave)
    );

    // host length wins while the override flag is set
    assign o_len = len_ovr ? len_pxi : wave;

    //////////////////////////////
    // motor neuron output
    //////////////////////////////

    spike_window u_spike_window (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_spike        (i_spike),
        .i_sim_tick     (o_sim_tick),
        .i_gain         (gain),
        .o_spike_cnt    (o_spike_cnt),
        .o_drive        (o_drive)
    );

endmodule

`default_nettype wire

/* spike_window.sv */
`timescale 1ns/10ps
`default_nettype none

module spike_window
    import motor_pkg::*;
(
    input  wire        i_ep50trig,
    input  wire        i_reset_global,
    input  wire        i_spike,
    input  wire        i_sim_tick,
    input  wire word_t i_gain,
    output spike_cnt_t o_spike_cnt,
    output word_t      o_drive
);

    spike_cnt_t win_cnt;
    spike_cnt_t win_start;
    word_t      drive_prod;

    // spike on the tick opens the next window
    assign win_start  = i_spike ? spike_cnt_t'(1) : '0;
    // low word of count times gain
    assign drive_prod = word_t'(win_cnt) * i_gain;

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            win_cnt     <= '0;
            o_spike_cnt <= '0;
            o_drive     <= '0;
        end
        else if (i_sim_tick)
        begin
            // publish the closed window
            win_cnt     <= win_start;
            o_spike_cnt <= win_cnt;
            o_drive     <= drive_prod;
        end
        else if (i_spike && (win_cnt != '1))
        begin
            // saturate instead of wrapping
            win_cnt <= win_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb_reflex_checks.svh */
`ifndef TB_REFLEX_CHECKS_SVH
`define TB_REFLEX_CHECKS_SVH

//////////////////////////////
// run exit on failure
//////////////////////////////

task automatic halt_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first failure");
endtask

//////////////////////////////
// typed compares
//////////////////////////////

// full words such as length and drive
task automatic word_check(
    input string what,
    input word_t got,
    input word_t exp
);
    if (got !== exp)
    begin
        $display("[ERROR] %0t ns: %s is %h, model expects %h", $time, what, got, exp);
        halt_run();
    end
endtask

// spike count of a closed window
task automatic count_check(
    input string      what,
    input spike_cnt_t got,
    input spike_cnt_t exp
);
    if (got !== exp)
    begin
        $display("[ERROR] %0t ns: %s is %0d, model expects %0d", $time, what, got, exp);
        halt_run();
    end
endtask

// simulation tick pulse
task automatic tick_check(
    input logic got,
    input logic exp
);
    if (got !== exp)
    begin
        $display("[ERROR] %0t ns: o_sim_tick is %b, model expects %b", $time, got, exp);
        halt_run();
    end
endtask

`endif

/* tb_reflex_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "motor_cfg.svh"

module tb_reflex_core
    import motor_pkg::*;
();

    // phase lengths in clock cycles
    localparam int RESET_CYCLES = 16;
    localparam int TICK_LOADS   = 3;
    localparam int TICK_RUN     = 100;
    localparam int WAVE_ROUNDS  = 6;
    localparam int MAX_FEED     = 4 * 20;
    localparam int PLAY_RUN     = 120;
    localparam int OVR_RUN      = 40;
    localparam int SPIKE_LOADS  = 3;
    localparam int SPIKE_RUN    = 200;
    localparam int PLANNED_CYCLES = RESET_CYCLES + TICK_LOADS * (TICK_RUN + 1) + 1
        + WAVE_ROUNDS * (2 + MAX_FEED + PLAY_RUN) + 3 + 2 * OVR_RUN + 1
        + SPIKE_LOADS * (SPIKE_RUN + 1);
    localparam int WATCH_CYCLES = PLANNED_CYCLES + 500;

    logic        ep50trig = 1'b0;
    logic        reset_global;
    logic [15:0] trig;
    half_t       wire_lo;
    half_t       wire_hi;
    logic        pipe_write;
    half_t       pipe_data;
    logic        wave_restart;
    logic        spike;
    logic        spike_on;
    logic        sim_tick;
    word_t       len;
    spike_cnt_t  spike_cnt;
    word_t       drive;
    integer      seed;

    // reference model state
    half_t      m_half;
    word_t      m_gain;
    logic       m_ovr;
    word_t      m_pxi;
    half_t      m_step;
    logic       m_tick;
    word_t      m_mem [`MOTOR_WAVE_DEPTH];
    half_t      m_lo;
    logic       m_pair_hi;
    int         m_fill;
    int         m_ptr;
    word_t      m_wave;
    spike_cnt_t m_win;
    spike_cnt_t m_cnt;
    word_t      m_drive;

    `include "tb_reflex_checks.svh"

    reflex_core UUT (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_trig         (trig),
        .i_wire_lo      (wire_lo),
        .i_wire_hi      (wire_hi),
        .i_pipe_write   (pipe_write),
        .i_pipe_data    (pipe_data),
        .i_wave_restart (wave_restart),
        .i_spike        (spike),
        .o_sim_tick     (sim_tick),
        .o_len          (len),
        .o_spike_cnt    (spike_cnt),
        .o_drive        (drive)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #4 ep50trig = ~ep50trig;
    end

    //////////////////////////////
    // cycle model
    //////////////////////////////

    // one clock edge
    // inputs as driven on the last falling edge
    task automatic step_model();
        int nxt;
        // spike window sees the tick and gain from before the edge
        if (reset_global)
        begin
            m_win   = '0;
            m_cnt   = '0;
            m_drive = '0;
        end
        else if (m_tick)
        begin
            m_cnt   = m_win;
            m_drive = word_t'(m_win) * m_gain;
            // tick-cycle spike opens the next window
            m_win   = spike ? spike_cnt_t'(1) : '0;
        end
        else if (spike && (m_win != '1))
            m_win = m_win + 1'b1;
        // waveform store
        if (reset_global || wave_restart)
        begin
            m_fill    = 0;
            m_ptr     = 0;
            m_pair_hi = 1'b0;
            m_wave    = '0;
        end
        else
        begin
            if (m_tick && (m_fill > 0))
            begin
                nxt    = (m_ptr + 1 >= m_fill) ? 0 : m_ptr + 1;
                m_ptr  = nxt;
                m_wave = m_mem[nxt];
            end
            // full store drops the word
            if (pipe_write && (m_fill < `MOTOR_WAVE_DEPTH))
            begin
                if (m_pair_hi)
                begin
                    m_mem[m_fill] = {pipe_data, m_lo};
                    m_fill = m_fill + 1;
                end
                else
                    m_lo = pipe_data;
                m_pair_hi = !m_pair_hi;
            end
        end
        // tick timer on the old half-count
        if (reset_global)
        begin
            m_step = '0;
            m_tick = 1'b0;
        end
        else if (m_step >= m_half)
        begin
            m_step = '0;
            m_tick = 1'b1;
        end
        else
        begin
            m_step = m_step + 1'b1;
            m_tick = 1'b0;
        end
        // host parameters last
        if (reset_global)
        begin
            m_half = `MOTOR_DEF_HALF_CNT;
            m_gain = `MOTOR_DEF_GAIN;
            m_ovr  = 1'b0;
            m_pxi  = `MOTOR_DEF_LEN_PXI;
        end
        else
        begin
            if (trig[`MOTOR_SLOT_HALF_CNT])
                m_half = wire_lo;
            if (trig[`MOTOR_SLOT_GAIN])
                m_gain = {wire_hi, wire_lo};
            if (trig[`MOTOR_SLOT_LEN_OVR])
                m_ovr = wire_lo[0];
            if (trig[`MOTOR_SLOT_LEN_PXI])
                m_pxi = {wire_hi, wire_lo};
        end
    endtask

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // step, compare, then drive the next cycle on the falling edge
    task automatic run_cycle();
        integer r;
        @(negedge ep50trig);
        step_model();
        tick_check(sim_tick, m_tick);
        word_check("o_len", len, m_ovr ? m_pxi : m_wave);
        count_check("o_spike_cnt", spike_cnt, m_cnt);
        word_check("o_drive", drive, m_drive);
        // strobes last a single cycle
        r          = $random(seed);
        trig       = '0;
        pipe_write = 1'b0;
        spike      = spike_on & r[0];
    endtask

    task automatic load_slot(input int slot, input half_t hi, input half_t lo);
        trig       = '0;
        trig[slot] = 1'b1;
        wire_hi    = hi;
        wire_lo    = lo;
        run_cycle();
    endtask

    task automatic restart_store();
        wave_restart = 1'b1;
        run_cycle();
        // store emptied while the override is off
        word_check("o_len after restart", len, '0);
        run_cycle();
        wave_restart = 1'b0;
    endtask

    // low half first
    // some words are followed by an idle gap
    task automatic feed_pairs(input int pairs);
        integer r;
        for (int i = 0; i < 2 * pairs; i++)
        begin
            r          = $random(seed);
            pipe_write = 1'b1;
            pipe_data  = half_t'(r);
            run_cycle();
            if (r[16])
                run_cycle();
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial
    begin
        integer h;
        integer n;
        seed         = 32'hf6cc_daa3;
        reset_global = 1'b1;
        trig         = '0;
        wire_lo      = '0;
        wire_hi      = '0;
        pipe_write   = 1'b0;
        pipe_data    = '0;
        wave_restart = 1'b0;
        spike        = 1'b0;
        spike_on     = 1'b0;
        repeat (RESET_CYCLES) run_cycle();
        reset_global = 1'b0;
        // outputs straight out of reset
        word_check("o_len after reset", len, '0);
        count_check("o_spike_cnt after reset", spike_cnt, '0);
        word_check("o_drive after reset", drive, '0);
        tick_check(sim_tick, 1'b0);
        // tick spacing for random half-counts
        repeat (TICK_LOADS)
        begin
            h = 1 + ({$random(seed)} % 20);
            load_slot(`MOTOR_SLOT_HALF_CNT, '0, half_t'(h));
            repeat (TICK_RUN) run_cycle();
        end
        // fill and playback with short steps
        load_slot(`MOTOR_SLOT_HALF_CNT, '0, half_t'(1 + ({$random(seed)} % 6)));
        repeat (WAVE_ROUNDS)
        begin
            restart_store();
            n = 1 + ({$random(seed)} % 20);
            feed_pairs(n);
            repeat (PLAY_RUN) run_cycle();
        end
        // host length override
        // only bit 0 of the flag word counts
        load_slot(`MOTOR_SLOT_LEN_PXI, half_t'($random(seed)), half_t'($random(seed)));
        load_slot(`MOTOR_SLOT_LEN_OVR, '0, half_t'($random(seed)) | 16'h0001);
        repeat (OVR_RUN) run_cycle();
        load_slot(`MOTOR_SLOT_LEN_OVR, '0, half_t'($random(seed)) & 16'hfffe);
        repeat (OVR_RUN) run_cycle();
        // spike windows with a random gain
        spike_on = 1'b1;
        load_slot(`MOTOR_SLOT_GAIN, half_t'($random(seed)), half_t'($random(seed)));
        repeat (SPIKE_LOADS)
        begin
            h = 1 + ({$random(seed)} % 20);
            load_slot(`MOTOR_SLOT_HALF_CNT, '0, half_t'(h));
            repeat (SPIKE_RUN) run_cycle();
        end
        $display("TEST OK");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WATCH_CYCLES) @(posedge ep50trig);
        $display("run timed out after %0d clock cycles", WATCH_CYCLES);
        halt_run();
    end

endmodule

`default_nettype wire

/* tick_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tick_gen
    import motor_pkg::*;
(
    input  wire        i_ep50trig,
    input  wire        i_reset_global,
    input  wire half_t i_half_cnt,
    output logic       o_sim_tick
);

    half_t step_cnt;
    logic  step_done;

    // reaches or exceeds
    // a smaller half-count loaded mid-step ends the step right away
    assign step_done = (step_cnt >= i_half_cnt);

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            step_cnt   <= '0;
            o_sim_tick <= 1'b0;
        end
        else if (step_done)
        begin
            // restart the step and flag it for one cycle
            step_cnt   <= '0;
            o_sim_tick <= 1'b1;
        end
        else
        begin
            step_cnt   <= step_cnt + 1'b1;
            o_sim_tick <= 1'b0;
        end
    end

    // back to back ticks need a zero half-count in between
    a_tick_spacing: assert property (
        @(posedge i_ep50trig) disable iff (i_reset_global)
        o_sim_tick |=> !o_sim_tick || ($past(i_half_cnt) == '0)
    );

endmodule

`default_nettype wire

/* wave_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "motor_cfg.svh"

module wave_buffer
    import motor_pkg::*;
(
    input  wire             i_ep50trig,
    input  wire             i_reset_global,
    input  wire             i_wave_restart,
    input  wire half_t      i_pipe_data,
    input  wire             i_wr_en,
    input  wire             i_pair_hi,
    input  wire wave_addr_t i_wr_addr,
    input  wire             i_rd_en,
    input  wire wave_addr_t i_rd_addr,
    output word_t           o_wave
);

    word_t mem [`MOTOR_WAVE_DEPTH];
    half_t lo_q;

    //////////////////////////////
    // sample assembly
    //////////////////////////////

    // low half waits for its partner
    always_ff @(posedge i_ep50trig)
    begin
        if (i_wr_en && !i_pair_hi)
            lo_q <= i_pipe_data;
    end

    // high half completes the word
    always_ff @(posedge i_ep50trig)
    begin
        if (i_wr_en && i_pair_hi)
            mem[i_wr_addr] <= {i_pipe_data, lo_q};
    end

    // played sample, held between ticks
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || i_wave_restart)
            o_wave <= '0;
        else if (i_rd_en)
            o_wave <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

/* wave_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "motor_cfg.svh"

module wave_ctrl
    import motor_pkg::*;
(
    input  wire        i_ep50trig,
    input  wire        i_reset_global,
    input  wire        i_wave_restart,
    input  wire        i_pipe_write,
    input  wire        i_sim_tick,
    output logic       o_wr_en,
    output wave_addr_t o_wr_addr,
    output logic       o_rd_en,
    output wave_addr_t o_rd_addr,
    output logic       o_pair_hi
);

    // fill count has to reach the depth itself
    localparam int FILL_W = $clog2(`MOTOR_WAVE_DEPTH + 1);

    wave_state_e       state_q;
    wave_state_e       state_d;
    logic [FILL_W-1:0] fill_cnt;
    logic [FILL_W-1:0] ptr_inc;
    wave_addr_t        rd_ptr;
    wave_addr_t        rd_ptr_next;
    logic              pair_hi_q;
    logic              store_full;
    logic              sample_done;
    logic              clear;

    assign clear      = i_reset_global | i_wave_restart;
    assign store_full = (fill_cnt == FILL_W'(`MOTOR_WAVE_DEPTH));

    //////////////////////////////
    // fill side
    //////////////////////////////

    // words past a full store are dropped
    assign o_wr_en     = i_pipe_write && !store_full;
    assign o_pair_hi   = pair_hi_q;
    // high half closes a sample
    assign sample_done = o_wr_en && pair_hi_q;
    assign o_wr_addr   = wave_addr_t'(fill_cnt);

    //////////////////////////////
    // playback side
    //////////////////////////////

    // advance first, wrap at the fill count
    assign ptr_inc     = FILL_W'(rd_ptr) + FILL_W'(1);
    assign rd_ptr_next = (ptr_inc >= fill_cnt) ? '0 : wave_addr_t'(ptr_inc);
    // nothing to play while empty
    assign o_rd_en     = i_sim_tick && (state_q != EMPTY);
    assign o_rd_addr   = rd_ptr_next;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            EMPTY:   if (sample_done) state_d = FILL;
            FILL:    if (i_sim_tick) state_d = PLAY;
            PLAY:    state_d = PLAY;
            default: state_d = EMPTY;
        endcase
    end

    always_ff @(posedge i_ep50trig)
    begin
        if (clear)
        begin
            state_q   <= EMPTY;
            fill_cnt  <= '0;
            rd_ptr    <= '0;
            pair_hi_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            // low and high halves alternate
            if (o_wr_en)
                pair_hi_q <= !pair_hi_q;
            if (sample_done)
                fill_cnt <= fill_cnt + 1'b1;
            if (o_rd_en)
                rd_ptr <= rd_ptr_next;
        end
    end

    a_fill_bound: assert property (
        @(posedge i_ep50trig) disable iff (i_reset_global)
        fill_cnt <= FILL_W'(`MOTOR_WAVE_DEPTH)
    );

endmodule

`default_nettype wire
